// ==== sim.f ====
tx_pkg.sv
tx_fifo.sv
tx_mmr.sv
tx_ctrl.sv
tx_csum.sv
tx_core.sv
tx_core_asserts.sv
tb_tx_core.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_tx_core -f sim.f -Mdir obj_dir
	./obj_dir/Vtb_tx_core +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_tx_core.sv ====
// Testbench for the transmit channel
// Random descriptors and MAC pops checked against a queue model
`timescale 1ns/1ns

module tb_tx_core;
	import tx_pkg::*;

	localparam int TIMEOUT = 4000;

	logic clock;
	logic arst_n_i;
	logic reg_wr_en_i;
	reg_addr_t reg_addr_i;
	word_t reg_wr_data_i;
	word_t reg_rd_data_o;
	logic mem_rd_en_o;
	addr_t mem_addr_o;
	word_t mem_rd_data_i;
	logic meta_rd_en_i;
	len_t meta_data_o;
	logic meta_empty_o;
	logic data_rd_en_i;
	word_t data_o;
	logic data_empty_o;
	logic csum_rd_en_i;
	csum_t csum_o;
	logic csum_empty_o;
	logic channel_irq_o;

	integer seed = 32'hd129c162;
	int error_count = 0;
	int timeout_count = 0;
	int frame_count = 0;
	logic mac_on = 1'b0;
	logic rd_pend = 1'b0;
	addr_t rd_addr;
	word_t mem [256];
	word_t exp_data [$];
	len_t exp_len [$];
	csum_t exp_csum [$];

	tx_core u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// One's-complement add with end-around carry
	function automatic csum_t add_ones(input csum_t a, input csum_t b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + 16'(s[16]);
	endfunction

	function automatic csum_t frame_csum(input logic [7:0] idx, input len_t len);
		csum_t sum;
		word_t w;
		sum = '0;
		for (int i = 0; i < len; i++) begin
			w = mem[idx + 8'(i)];
			sum = add_ones(add_ones(sum, w[15:0]), w[31:16]);
		end
		return ~sum;
	endfunction

	// Memory answers one cycle after each read strobe
	always @(negedge clock) begin
		rd_pend = mem_rd_en_o;
		rd_addr = mem_addr_o;
	end

	always @(posedge clock) begin
		word_t r;
		#1;
		if (rd_pend)
			mem_rd_data_i = mem[rd_addr[9:2]];
		r = $random(seed);
		data_rd_en_i = mac_on && (r[1:0] != 2'b00);
		meta_rd_en_i = mac_on && r[2];
		csum_rd_en_i = mac_on && r[3];
	end

	// Compare each FIFO head that the MAC pops at the coming edge
	always @(negedge clock) begin
		if (data_rd_en_i && !data_empty_o) begin
			if (exp_data.size() == 0) begin
				$display("Data word popped while no word was expected");
				error_count++;
			end else
				check_value("data_o", data_o, exp_data.pop_front());
		end
		if (meta_rd_en_i && !meta_empty_o) begin
			if (exp_len.size() == 0) begin
				$display("Meta entry popped while no frame was expected");
				error_count++;
			end else
				check_value("meta_data_o", 32'(meta_data_o), 32'(exp_len.pop_front()));
		end
		if (csum_rd_en_i && !csum_empty_o) begin
			if (exp_csum.size() == 0) begin
				$display("Checksum popped while no frame was expected");
				error_count++;
			end else
				check_value("csum_o", 32'(csum_o), 32'(exp_csum.pop_front()));
		end
	end

	task automatic reg_write(input reg_addr_t addr, input word_t data);
		@(posedge clock);
		#1;
		reg_wr_en_i = 1'b1;
		reg_addr_i = addr;
		reg_wr_data_i = data;
		@(posedge clock);
		#1;
		reg_wr_en_i = 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t addr, output word_t data);
		@(posedge clock);
		#1;
		reg_addr_i = addr;
		@(negedge clock);
		data = reg_rd_data_o;
	endtask

	task automatic queue_frame(input logic [7:0] idx, input len_t len, output logic ok);
		word_t st;
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			reg_read(REG_STATUS, st);
			if (!st[16])
				break;
		end
		ok = (n < TIMEOUT);
		if (!ok) begin
			$display("Timeout: descriptor FIFO stayed full");
			timeout_count++;
			return;
		end
		for (int i = 0; i < len; i++)
			exp_data.push_back(mem[idx + 8'(i)]);
		exp_len.push_back(len);
		exp_csum.push_back(frame_csum(idx, len));
		reg_write(REG_DESC_ADDR, {22'b0, idx, 2'b00});
		reg_write(REG_DESC_LEN, {24'b0, len});
		frame_count++;
	endtask

	task automatic random_frame(output logic ok);
		word_t r;
		r = $random(seed);
		queue_frame(r[7:0], 8'd1 + 8'(r[12:8] % 5'd20), ok);
	endtask

	task automatic wait_drained(output logic ok);
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clock);
			if (exp_data.size() == 0 && exp_len.size() == 0 && exp_csum.size() == 0)
				break;
		end
		ok = (n < TIMEOUT);
		if (!ok) begin
			$display("Timeout: frames did not drain from the MAC side FIFOs");
			timeout_count++;
		end
	endtask

	task automatic run_tests();
		word_t rd;
		logic ok;
		@(negedge clock);
		check_value("mem_rd_en_o", 32'(mem_rd_en_o), 32'h0);
		check_value("channel_irq_o", 32'(channel_irq_o), 32'h0);
		check_value("empties", 32'({meta_empty_o, data_empty_o, csum_empty_o}), 32'h7);
		reg_read(REG_STATUS, rd);
		check_value("REG_STATUS", rd, 32'h0);
		reg_read(REG_CTRL, rd);
		check_value("REG_CTRL", rd, 32'h0);
		reg_read(REG_DESC_ADDR, rd);
		check_value("REG_DESC_ADDR", rd, 32'h0);
		reg_write(REG_CTRL, 32'h2);
		reg_read(REG_CTRL, rd);
		check_value("REG_CTRL", rd, 32'h2);
		reg_write(REG_DESC_ADDR, 32'h0000_0a5c);
		reg_read(REG_DESC_ADDR, rd);
		check_value("REG_DESC_ADDR", rd, 32'h0000_0a5c);
		mac_on = 1'b1;
		// Channel disabled with frames queued
		for (int f = 0; f < 3; f++) begin
			random_frame(ok);
			if (!ok)
				return;
		end
		repeat (30) begin
			@(negedge clock);
			check_value("mem_rd_en_o", 32'(mem_rd_en_o), 32'h0);
			check_value("data_empty_o", 32'(data_empty_o), 32'h1);
		end
		reg_write(REG_CTRL, 32'h3);
		for (int f = 0; f < 30; f++) begin
			random_frame(ok);
			if (!ok)
				return;
		end
		wait_drained(ok);
		if (!ok)
			return;
		repeat (4) @(negedge clock);
		check_value("empties", 32'({meta_empty_o, data_empty_o, csum_empty_o}), 32'h7);
		check_value("channel_irq_o", 32'(channel_irq_o), 32'h1);
		reg_read(REG_STATUS, rd);
		check_value("status count", 32'(rd[15:8]), 32'(frame_count[7:0]));
		check_value("status pending", 32'(rd[0]), 32'h1);
		// Masking the interrupt keeps the pending bit
		reg_write(REG_CTRL, 32'h1);
		@(negedge clock);
		check_value("channel_irq_o", 32'(channel_irq_o), 32'h0);
		reg_read(REG_STATUS, rd);
		check_value("status pending", 32'(rd[0]), 32'h1);
		reg_write(REG_CTRL, 32'h3);
		@(negedge clock);
		check_value("channel_irq_o", 32'(channel_irq_o), 32'h1);
		reg_write(REG_STATUS, 32'h1);
		@(negedge clock);
		check_value("channel_irq_o", 32'(channel_irq_o), 32'h0);
	endtask

	initial begin
		arst_n_i = 1'b0;
		reg_wr_en_i = 1'b0;
		reg_addr_i = '0;
		reg_wr_data_i = '0;
		mem_rd_data_i = '0;
		meta_rd_en_i = 1'b0;
		data_rd_en_i = 1'b0;
		csum_rd_en_i = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = $random(seed);
		repeat (8) @(posedge clock);
		#1;
		arst_n_i = 1'b1;
		run_tests();
		$display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
			error_count, timeout_count, u_dut.u_asserts.fail_count);
		if (error_count == 0 && timeout_count == 0 && u_dut.u_asserts.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tx_core_asserts.sv ====
// Transmit channel assertions
// Read alignment, data FIFO overflow and interrupt gating
`timescale 1ns/1ns

module tx_core_asserts (
	input wire logic clock,
	input wire logic arst_n_i,
	input wire logic reg_wr_en_i,
	input tx_pkg::reg_addr_t reg_addr_i,
	input tx_pkg::word_t reg_wr_data_i,
	input wire logic mem_rd_en_i,
	input tx_pkg::addr_t mem_addr_i,
	input wire logic data_push_i,
	input wire logic data_full_i,
	input wire logic channel_irq_i
);
	import tx_pkg::*;

	int fail_count = 0;
	logic irq_en_q;

	// Interrupt enable as last written through the register port
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i)
			irq_en_q <= 1'b0;
		else if (reg_wr_en_i && (reg_addr_i == REG_CTRL))
			irq_en_q <= reg_wr_data_i[CTRL_IRQ_EN_BIT];
	end

	a_read_aligned: assert property (@(posedge clock) disable iff (!arst_n_i)
		mem_rd_en_i |-> (mem_addr_i[1:0] == 2'b00))
	else begin
		$error("Memory read address is not word aligned");
		fail_count++;
	end

	a_no_data_overflow: assert property (@(posedge clock) disable iff (!arst_n_i)
		data_push_i |-> !data_full_i)
	else begin
		$error("Data FIFO pushed while full");
		fail_count++;
	end

	a_irq_gated: assert property (@(posedge clock) disable iff (!arst_n_i)
		channel_irq_i |-> irq_en_q)
	else begin
		$error("Channel interrupt raised with interrupt enable clear");
		fail_count++;
	end

endmodule

bind tx_core tx_core_asserts u_asserts (
	.clock(clock),
	.arst_n_i(arst_n_i),
	.reg_wr_en_i(reg_wr_en_i),
	.reg_addr_i(reg_addr_i),
	.reg_wr_data_i(reg_wr_data_i),
	.mem_rd_en_i(mem_rd_en_o),
	.mem_addr_i(mem_addr_o),
	.data_push_i(word_valid),
	.data_full_i(data_full),
	.channel_irq_i(channel_irq_o)
);

// ==== tx_core.sv ====
// Transmit channel top level
// Register block, DMA controller, checksum unit and the four FIFOs
`timescale 1ns/1ns

module tx_core (
	input wire logic clock,
	input wire logic arst_n_i,
	input wire logic reg_wr_en_i,
	input tx_pkg::reg_addr_t reg_addr_i,
	input tx_pkg::word_t reg_wr_data_i,
	output tx_pkg::word_t reg_rd_data_o,
	output logic mem_rd_en_o,
	output tx_pkg::addr_t mem_addr_o,
	input tx_pkg::word_t mem_rd_data_i,
	input wire logic meta_rd_en_i,
	output tx_pkg::len_t meta_data_o,
	output logic meta_empty_o,
	input wire logic data_rd_en_i,
	output tx_pkg::word_t data_o,
	output logic data_empty_o,
	input wire logic csum_rd_en_i,
	output tx_pkg::csum_t csum_o,
	output logic csum_empty_o,
	output logic channel_irq_o
);
	import tx_pkg::*;

	logic enable;
	logic desc_push;
	desc_t desc_in;
	logic desc_pop;
	desc_t desc_head;
	logic desc_empty;
	logic desc_full;
	logic meta_push;
	len_t meta_len;
	logic meta_full;
	logic [DATA_COUNT_WIDTH-1:0] data_count;
	logic data_full;
	logic word_valid;
	word_t word;
	logic sof;
	logic eof;
	logic csum_push;
	csum_t csum_val;
	logic csum_full;
	logic frame_done;

	// A frame is done once its checksum is queued
	assign frame_done = csum_push;

	tx_mmr tx_mmr_0 (
		.clock, .arst_n_i,
		.reg_wr_en_i, .reg_addr_i, .reg_wr_data_i, .reg_rd_data_o,
		.desc_full_i(desc_full), .frame_done_i(frame_done),
		.enable_o(enable), .desc_push_o(desc_push), .desc_o(desc_in),
		.channel_irq_o
	);

	tx_ctrl tx_ctrl_0 (
		.clock, .arst_n_i,
		.enable_i(enable), .desc_empty_i(desc_empty), .desc_i(desc_head),
		.meta_full_i(meta_full), .data_count_i(data_count), .csum_full_i(csum_full),
		.mem_rd_data_i,
		.desc_pop_o(desc_pop), .meta_push_o(meta_push), .meta_len_o(meta_len),
		.mem_rd_en_o, .mem_addr_o,
		.word_valid_o(word_valid), .word_o(word), .sof_o(sof), .eof_o(eof)
	);

	tx_csum tx_csum_0 (
		.clock, .arst_n_i,
		.word_valid_i(word_valid), .word_i(word), .sof_i(sof), .eof_i(eof),
		.csum_push_o(csum_push), .csum_o(csum_val)
	);

	tx_fifo #(.WIDTH(DESC_WIDTH), .DEPTH(DESC_FIFO_DEPTH)) desc_fifo (
		.clock, .arst_n_i,
		.push_i(desc_push), .push_data_i(desc_in), .pop_i(desc_pop),
		.head_o(desc_head), .empty_o(desc_empty), .full_o(desc_full), .count_o()
	);

	tx_fifo #(.WIDTH(LEN_WIDTH), .DEPTH(META_FIFO_DEPTH)) meta_fifo (
		.clock, .arst_n_i,
		.push_i(meta_push), .push_data_i(meta_len), .pop_i(meta_rd_en_i),
		.head_o(meta_data_o), .empty_o(meta_empty_o), .full_o(meta_full), .count_o()
	);

	tx_fifo #(.WIDTH(WORD_WIDTH), .DEPTH(DATA_FIFO_DEPTH)) data_fifo (
		.clock, .arst_n_i,
		.push_i(word_valid), .push_data_i(word), .pop_i(data_rd_en_i),
		.head_o(data_o), .empty_o(data_empty_o), .full_o(data_full), .count_o(data_count)
	);

	tx_fifo #(.WIDTH(CSUM_WIDTH), .DEPTH(CSUM_FIFO_DEPTH)) csum_fifo (
		.clock, .arst_n_i,
		.push_i(csum_push), .push_data_i(csum_val), .pop_i(csum_rd_en_i),
		.head_o(csum_o), .empty_o(csum_empty_o), .full_o(csum_full), .count_o()
	);

endmodule

// ==== tx_csum.sv ====
// Per-frame one's-complement checksum
// Sums both 16-bit halves of each word with end-around carry
`timescale 1ns/1ns

module tx_csum (
	input wire logic clock,
	input wire logic arst_n_i,
	input wire logic word_valid_i,
	input tx_pkg::word_t word_i,
	input wire logic sof_i,
	input wire logic eof_i,
	output logic csum_push_o,
	output tx_pkg::csum_t csum_o
);
	import tx_pkg::*;

	localparam int SUM_WIDTH = CSUM_WIDTH + 2;
	localparam int FOLD_WIDTH = CSUM_WIDTH + 1;

	csum_t sum_q;
	csum_t base;
	logic [SUM_WIDTH-1:0] total;
	logic [FOLD_WIDTH-1:0] fold;
	csum_t sum_d;

	// Start from zero on the first word of a frame
	assign base = sof_i ? '0 : sum_q;
	assign total = SUM_WIDTH'(base) + SUM_WIDTH'(word_i[CSUM_WIDTH-1:0])
		+ SUM_WIDTH'(word_i[WORD_WIDTH-1:CSUM_WIDTH]);
	// Two folds bring every carry back in
	assign fold = FOLD_WIDTH'(total[CSUM_WIDTH-1:0])
		+ FOLD_WIDTH'(total[SUM_WIDTH-1:CSUM_WIDTH]);
	assign sum_d = fold[CSUM_WIDTH-1:0] + CSUM_WIDTH'(fold[CSUM_WIDTH]);

	always_ff @(posedge clock) begin
		if (word_valid_i)
			sum_q <= sum_d;
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i)
			csum_push_o <= 1'b0;
		else
			csum_push_o <= word_valid_i && eof_i;
	end

	assign csum_o = ~sum_q;

endmodule

// ==== tx_ctrl.sv ====
// Transmit DMA controller
// Pops descriptors, issues one memory read per word and tags
// each returning word with its frame boundaries
`timescale 1ns/1ns

module tx_ctrl (
	input wire logic clock,
	input wire logic arst_n_i,
	input wire logic enable_i,
	input wire logic desc_empty_i,
	input tx_pkg::desc_t desc_i,
	input wire logic meta_full_i,
	input wire logic [tx_pkg::DATA_COUNT_WIDTH-1:0] data_count_i,
	input wire logic csum_full_i,
	input tx_pkg::word_t mem_rd_data_i,
	output logic desc_pop_o,
	output logic meta_push_o,
	output tx_pkg::len_t meta_len_o,
	output logic mem_rd_en_o,
	output tx_pkg::addr_t mem_addr_o,
	output logic word_valid_o,
	output tx_pkg::word_t word_o,
	output logic sof_o,
	output logic eof_o
);
	import tx_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	addr_t addr_q;
	len_t remain_q;
	logic first_q;
	logic room;
	logic issue;
	addr_t desc_addr;
	len_t desc_len;

	assign desc_addr = desc_i[DESC_WIDTH-1:LEN_WIDTH];
	assign desc_len = desc_i[LEN_WIDTH-1:0];

	// Two free entries, one for the read in flight and one for this read
	assign room = (data_count_i <= DATA_COUNT_WIDTH'(DATA_FIFO_DEPTH - 2));

	always_comb begin
		state_d = state_q;
		issue = 1'b0;
		case (state_q)
			S_IDLE: begin
				if (enable_i && !desc_empty_i && !meta_full_i)
					state_d = S_FETCH;
			end
			S_FETCH: begin
				state_d = (desc_len == LEN_WIDTH'(1)) ? S_LAST : S_READ;
			end
			S_READ: begin
				issue = enable_i && room;
				if (issue && remain_q == LEN_WIDTH'(2))
					state_d = S_LAST;
			end
			S_LAST: begin
				// Hold the last read until the checksum has somewhere to go
				issue = enable_i && room && !csum_full_i;
				if (issue)
					state_d = S_IDLE;
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_IDLE;
			remain_q <= '0;
			first_q <= 1'b0;
			word_valid_o <= 1'b0;
			sof_o <= 1'b0;
			eof_o <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == S_FETCH) begin
				remain_q <= desc_len;
				first_q <= 1'b1;
			end else if (issue) begin
				remain_q <= remain_q - 1'b1;
				first_q <= 1'b0;
			end
			// Flags line up with the data returned one cycle later
			word_valid_o <= issue;
			sof_o <= issue && first_q;
			eof_o <= issue && (state_q == S_LAST);
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == S_FETCH)
			addr_q <= desc_addr;
		else if (issue)
			addr_q <= addr_q + 32'd4;
	end

	assign desc_pop_o = (state_q == S_FETCH);
	assign meta_push_o = (state_q == S_FETCH);
	assign meta_len_o = desc_len;
	assign mem_rd_en_o = issue;
	assign mem_addr_o = addr_q;
	assign word_o = mem_rd_data_i;

endmodule

// ==== tx_mmr.sv ====
// Transmit channel register block
// Control and descriptor registers, status readback, completion interrupt
`timescale 1ns/1ns

module tx_mmr (
	input wire logic clock,
	input wire logic arst_n_i,
	input wire logic reg_wr_en_i,
	input tx_pkg::reg_addr_t reg_addr_i,
	input tx_pkg::word_t reg_wr_data_i,
	input wire logic desc_full_i,
	input wire logic frame_done_i,
	output tx_pkg::word_t reg_rd_data_o,
	output logic enable_o,
	output logic desc_push_o,
	output tx_pkg::desc_t desc_o,
	output logic channel_irq_o
);
	import tx_pkg::*;

	logic enable_q;
	logic irq_en_q;
	addr_t desc_addr_q;
	logic pending_q;
	logic [7:0] frame_cnt_q;
	logic wr_ctrl;
	logic wr_addr;
	logic wr_len;
	logic wr_status;

	assign wr_ctrl = reg_wr_en_i && (reg_addr_i == REG_CTRL);
	assign wr_addr = reg_wr_en_i && (reg_addr_i == REG_DESC_ADDR);
	assign wr_len = reg_wr_en_i && (reg_addr_i == REG_DESC_LEN);
	assign wr_status = reg_wr_en_i && (reg_addr_i == REG_STATUS);

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			enable_q <= 1'b0;
			irq_en_q <= 1'b0;
			desc_addr_q <= '0;
			pending_q <= 1'b0;
			frame_cnt_q <= '0;
		end else begin
			if (wr_ctrl) begin
				enable_q <= reg_wr_data_i[CTRL_EN_BIT];
				irq_en_q <= reg_wr_data_i[CTRL_IRQ_EN_BIT];
			end
			if (wr_addr)
				desc_addr_q <= reg_wr_data_i;
			if (frame_done_i)
				frame_cnt_q <= frame_cnt_q + 8'd1;
			// A new completion wins over a clear in the same cycle
			if (frame_done_i)
				pending_q <= 1'b1;
			else if (wr_status && reg_wr_data_i[0])
				pending_q <= 1'b0;
		end
	end

	// Length write pushes a descriptor, dropped when the FIFO is full
	assign desc_push_o = wr_len && !desc_full_i;
	assign desc_o = {desc_addr_q, reg_wr_data_i[LEN_WIDTH-1:0]};

	always_comb begin
		reg_rd_data_o = '0;
		case (reg_addr_i)
			REG_CTRL: begin
				reg_rd_data_o[CTRL_EN_BIT] = enable_q;
				reg_rd_data_o[CTRL_IRQ_EN_BIT] = irq_en_q;
			end
			REG_DESC_ADDR: reg_rd_data_o = desc_addr_q;
			REG_STATUS: begin
				reg_rd_data_o[0] = pending_q;
				reg_rd_data_o[15:8] = frame_cnt_q;
				reg_rd_data_o[16] = desc_full_i;
			end
			default: ;
		endcase
	end

	assign enable_o = enable_q;
	assign channel_irq_o = pending_q && irq_en_q;

endmodule

// ==== tx_fifo.sv ====
// Synchronous FIFO with first-word-fall-through head
// Push when full and pop when empty are ignored
`timescale 1ns/1ns

module tx_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input wire logic clock,
	input wire logic arst_n_i,
	input wire logic push_i,
	input wire logic [WIDTH-1:0] push_data_i,
	input wire logic pop_i,
	output logic [WIDTH-1:0] head_o,
	output logic empty_o,
	output logic full_o,
	output logic [$clog2(DEPTH+1)-1:0] count_o
);
	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr_q;
	logic [PTR_WIDTH-1:0] rd_ptr_q;
	logic [CNT_WIDTH-1:0] count_q;
	logic do_push;
	logic do_pop;

	// Wrap at DEPTH so non power of two depths work too
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr_q] <= push_data_i;
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	assign head_o = mem[rd_ptr_q];
	assign empty_o = (count_q == '0);
	assign full_o = (count_q == CNT_WIDTH'(DEPTH));
	assign count_o = count_q;

endmodule

// ==== tx_pkg.sv ====
// Transmit channel package
// Widths, register map, FIFO depths and the controller state type
package tx_pkg;

	localparam int WORD_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int LEN_WIDTH = 8;
	localparam int CSUM_WIDTH = 16;
	localparam int REG_ADDR_WIDTH = 4;
	localparam int DESC_WIDTH = ADDR_WIDTH + LEN_WIDTH;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [LEN_WIDTH-1:0] len_t;
	typedef logic [CSUM_WIDTH-1:0] csum_t;
	// Address in the upper bits, length in the low byte
	typedef logic [DESC_WIDTH-1:0] desc_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

	// Register byte offsets
	localparam reg_addr_t REG_CTRL = 4'h0;
	localparam reg_addr_t REG_DESC_ADDR = 4'h4;
	localparam reg_addr_t REG_DESC_LEN = 4'h8;
	localparam reg_addr_t REG_STATUS = 4'hC;

	// REG_CTRL bits
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_IRQ_EN_BIT = 1;

	// FIFO depths in entries
	localparam int DESC_FIFO_DEPTH = 4;
	localparam int META_FIFO_DEPTH = 4;
	localparam int CSUM_FIFO_DEPTH = 4;
	localparam int DATA_FIFO_DEPTH = 16;
	localparam int DATA_COUNT_WIDTH = $clog2(DATA_FIFO_DEPTH + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_READ,
		S_LAST
	} ctrl_state_t;

endpackage
